/* verilog/decodePkg.sv */
package decodePkg;

	// One instruction word, read as R-format or I-format
	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [15:0] imm;
		} i;
	} instrWord;

	//////////////////////////////////////////////////////////////////////
	// Opcodes
	//////////////////////////////////////////////////////////////////////
	localparam logic [5:0] OP_RTYPE  = 6'b000000;
	localparam logic [5:0] OP_REGIMM = 6'b000001; // BGEZ, BLTZ and the linking pair
	localparam logic [5:0] OP_J      = 6'b000010;
	localparam logic [5:0] OP_JAL    = 6'b000011;
	localparam logic [5:0] OP_BEQ    = 6'b000100;
	localparam logic [5:0] OP_BNE    = 6'b000101;
	localparam logic [5:0] OP_BLEZ   = 6'b000110;
	localparam logic [5:0] OP_BGTZ   = 6'b000111;
	localparam logic [5:0] OP_ADDI   = 6'b001000;
	localparam logic [5:0] OP_ADDIU  = 6'b001001;
	localparam logic [5:0] OP_SLTI   = 6'b001010;
	localparam logic [5:0] OP_SLTIU  = 6'b001011;
	localparam logic [5:0] OP_ANDI   = 6'b001100;
	localparam logic [5:0] OP_ORI    = 6'b001101;
	localparam logic [5:0] OP_XORI   = 6'b001110;
	localparam logic [5:0] OP_LUI    = 6'b001111;
	localparam logic [5:0] OP_COP0   = 6'b010000;
	localparam logic [5:0] OP_LB     = 6'b100000;
	localparam logic [5:0] OP_LH     = 6'b100001;
	localparam logic [5:0] OP_LW     = 6'b100011;
	localparam logic [5:0] OP_LBU    = 6'b100100;
	localparam logic [5:0] OP_LHU    = 6'b100101;
	localparam logic [5:0] OP_SB     = 6'b101000;
	localparam logic [5:0] OP_SH     = 6'b101001;
	localparam logic [5:0] OP_SW     = 6'b101011;

	// Funct field of R-type words
	localparam logic [5:0] FN_SLL = 6'd0, FN_SRL = 6'd2, FN_SRA = 6'd3;
	localparam logic [5:0] FN_SLLV = 6'd4, FN_SRLV = 6'd6, FN_SRAV = 6'd7;
	localparam logic [5:0] FN_JR = 6'd8, FN_JALR = 6'd9;
	localparam logic [5:0] FN_SYSCALL = 6'd12, FN_BREAK = 6'd13;
	localparam logic [5:0] FN_MFHI = 6'd16, FN_MTHI = 6'd17;
	localparam logic [5:0] FN_MFLO = 6'd18, FN_MTLO = 6'd19;
	localparam logic [5:0] FN_MULT = 6'd24, FN_MULTU = 6'd25;
	localparam logic [5:0] FN_DIV = 6'd26, FN_DIVU = 6'd27;
	localparam logic [5:0] FN_ADD = 6'd32, FN_ADDU = 6'd33;
	localparam logic [5:0] FN_SUB = 6'd34, FN_SUBU = 6'd35;
	localparam logic [5:0] FN_AND = 6'd36, FN_OR = 6'd37;
	localparam logic [5:0] FN_XOR = 6'd38, FN_NOR = 6'd39;
	localparam logic [5:0] FN_SLT = 6'd42, FN_SLTU = 6'd43;
	localparam logic [5:0] FN_ERET = 6'd24; // Only under OP_COP0

	// REGIMM rt codes and COP0 rs codes
	localparam logic [4:0] RT_BLTZ = 5'b00000, RT_BGEZ = 5'b00001;
	localparam logic [4:0] RT_BLTZAL = 5'b10000, RT_BGEZAL = 5'b10001;
	localparam logic [4:0] RS_MFC0 = 5'b00000, RS_MTC0 = 5'b00100;

	//////////////////////////////////////////////////////////////////////
	// Control encodings
	//////////////////////////////////////////////////////////////////////
	localparam logic [3:0] ALU_ADD = 4'd0, ALU_SUB = 4'd1, ALU_OR = 4'd2, ALU_AND = 4'd3;
	localparam logic [3:0] ALU_NOR = 4'd4, ALU_XOR = 4'd5, ALU_SLL = 4'd6, ALU_SRL = 4'd7;
	localparam logic [3:0] ALU_SRA = 4'd8, ALU_SLT = 4'd9, ALU_SLTU = 4'd10;
	localparam logic [3:0] ALU_ADDU = 4'd11, ALU_SUBU = 4'd12, ALU_NONE = 4'd15;

	localparam logic [1:0] EXT_ZERO = 2'd0, EXT_SIGN = 2'd1, EXT_UPPER = 2'd2;
	localparam logic [1:0] NPC_SEQ = 2'd0, NPC_BRANCH = 2'd1, NPC_JUMP = 2'd2, NPC_REG = 2'd3;
	localparam logic [1:0] MD_MULTU = 2'd0, MD_MULT = 2'd1, MD_DIVU = 2'd2, MD_DIV = 2'd3;

	localparam logic [2:0] DM_SB = 3'd0, DM_SH = 3'd1, DM_SW = 3'd2, DM_LBU = 3'd3;
	localparam logic [2:0] DM_LB = 3'd4, DM_LHU = 3'd5, DM_LH = 3'd6, DM_WORD = 3'd7;

	localparam logic [2:0] WB_HILO = 3'd0, WB_IMM = 3'd1, WB_ALU = 3'd2;
	localparam logic [2:0] WB_LINK = 3'd3, WB_MEM = 3'd4, WB_CP0 = 3'd5;

	localparam logic [1:0] DST_RT = 2'd0, DST_RD = 2'd1, DST_RA = 2'd2;

	// CP0 Cause.ExcCode values
	localparam logic [4:0] EXC_NONE = 5'd0, EXC_SYS = 5'd8, EXC_BP = 5'd9, EXC_RI = 5'd10;

endpackage

/* verilog/aluDecode.sv */
`timescale 1ns/10ps

module aluDecode (
	input decodePkg::instrWord instr,
	output logic [3:0] aluOp,
	output logic shamtSel,
	output logic [1:0] extOp,
	output logic hiLoWr,
	output logic mdStart,
	output logic [1:0] mdOp,
	output logic [1:0] hiLoWrSel,
	output logic hiLoRdSel,
	output logic hiLoAccess
);
	import decodePkg::*;

	logic isRtype;
	logic [5:0] funct;

	assign isRtype = (instr.r.op == OP_RTYPE);
	assign funct = instr.r.funct;

	//////////////////////////////////////////////////////////////////////
	// ALU operation
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		aluOp = ALU_NONE;
		case (instr.r.op)
			OP_RTYPE: begin
				case (funct)
					FN_ADD: aluOp = ALU_ADD;
					FN_ADDU: aluOp = ALU_ADDU;
					FN_SUB: aluOp = ALU_SUB;
					FN_SUBU: aluOp = ALU_SUBU;
					FN_AND: aluOp = ALU_AND;
					FN_OR: aluOp = ALU_OR;
					FN_NOR: aluOp = ALU_NOR;
					FN_XOR: aluOp = ALU_XOR;
					FN_SLL, FN_SLLV: aluOp = ALU_SLL; // Same shifter, amount source differs
					FN_SRL, FN_SRLV: aluOp = ALU_SRL;
					FN_SRA, FN_SRAV: aluOp = ALU_SRA;
					FN_SLT: aluOp = ALU_SLT;
					FN_SLTU: aluOp = ALU_SLTU;
					default: aluOp = ALU_NONE;
				endcase
			end
			OP_ADDI: aluOp = ALU_ADD;
			OP_ADDIU: aluOp = ALU_ADDU;
			OP_ANDI: aluOp = ALU_AND;
			OP_ORI: aluOp = ALU_OR;
			OP_XORI: aluOp = ALU_XOR;
			OP_SLTI: aluOp = ALU_SLT;
			OP_SLTIU: aluOp = ALU_SLTU;
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
			OP_SB, OP_SH, OP_SW: aluOp = ALU_ADD; // Address = base + offset
			default: aluOp = ALU_NONE;
		endcase
	end

	// Shift amount from the shamt field, not from rs
	assign shamtSel = isRtype && (funct inside {FN_SLL, FN_SRL, FN_SRA});

	always_comb begin
		case (instr.i.op)
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
			OP_SB, OP_SH, OP_SW: extOp = EXT_SIGN;
			OP_LUI: extOp = EXT_UPPER;
			default: extOp = EXT_ZERO; // ANDI, ORI, XORI
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// HI/LO multiply-divide unit
	//////////////////////////////////////////////////////////////////////
	assign mdStart = isRtype && (funct inside {FN_MULT, FN_MULTU, FN_DIV, FN_DIVU});

	always_comb begin
		hiLoWr = 1'b0;
		mdOp = MD_MULTU;
		if (isRtype) begin
			case (funct)
				FN_MULTU: hiLoWr = 1'b1;
				FN_MULT: begin
					hiLoWr = 1'b1;
					mdOp = MD_MULT;
				end
				FN_DIVU: begin
					hiLoWr = 1'b1;
					mdOp = MD_DIVU;
				end
				FN_DIV: begin
					hiLoWr = 1'b1;
					mdOp = MD_DIV;
				end
				FN_MTHI, FN_MTLO: hiLoWr = 1'b1;
				default: hiLoWr = 1'b0;
			endcase
		end
	end

	// 2 takes the unit's result, 1 writes HI from rs, 0 writes LO
	assign hiLoWrSel = mdStart ? 2'd2 : ((isRtype && funct == FN_MTHI) ? 2'd1 : 2'd0);
	assign hiLoRdSel = isRtype && (funct == FN_MFHI);
	assign hiLoAccess = hiLoWr || (isRtype && (funct inside {FN_MFHI, FN_MFLO}));

	always_comb begin
		mdImpliesWr: assert final (!mdStart || hiLoWr);
	end

endmodule

/* verilog/memDecode.sv */
`timescale 1ns/10ps

module memDecode (
	input decodePkg::instrWord instr,
	output logic dmRd,
	output logic dmWr,
	output logic [2:0] dmSel
);
	import decodePkg::*;

	assign dmRd = instr.i.op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};

	always_comb begin
		case (instr.i.op)
			OP_SB, OP_SH, OP_SW: dmWr = 1'b1;
			default: dmWr = 1'b0;
		endcase
	end

	// Access size and sign handling for the data memory
	always_comb begin
		case (instr.i.op)
			OP_SB: dmSel = DM_SB;
			OP_SH: dmSel = DM_SH;
			OP_SW: dmSel = DM_SW;
			OP_LBU: dmSel = DM_LBU;
			OP_LB: dmSel = DM_LB;
			OP_LHU: dmSel = DM_LHU;
			OP_LH: dmSel = DM_LH;
			default: dmSel = DM_WORD; // LW and everything else
		endcase
	end

	always_comb begin
		rdWrExclusive: assert final (!(dmRd && dmWr));
	end

endmodule

/* verilog/branchDecode.sv */
`timescale 1ns/10ps

module branchDecode (
	input decodePkg::instrWord instr,
	input logic cmpEqual,
	input logic [1:0] cmpSign,
	output logic isBranch,
	output logic bjOp,
	output logic [1:0] npcOp
);
	import decodePkg::*;

	logic isJumpReg;
	logic isRegimmBr;
	logic condBranch;
	logic rsNeg;
	logic rsPos;

	assign isJumpReg = (instr.r.op == OP_RTYPE) && (instr.r.funct inside {FN_JR, FN_JALR});
	assign isRegimmBr = (instr.i.op == OP_REGIMM)
		&& (instr.i.rt inside {RT_BLTZ, RT_BGEZ, RT_BLTZAL, RT_BGEZAL});

	assign rsNeg = (cmpSign == 2'b10);
	assign rsPos = (cmpSign == 2'b01);

	always_comb begin
		case (instr.i.op)
			OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: condBranch = 1'b1;
			OP_REGIMM: condBranch = isRegimmBr;
			default: condBranch = 1'b0;
		endcase
	end

	assign bjOp = condBranch || isJumpReg;
	assign isBranch = bjOp || (instr.i.op == OP_J) || (instr.i.op == OP_JAL);

	//////////////////////////////////////////////////////////////////////
	// Next-PC select
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		npcOp = NPC_SEQ;
		case (instr.i.op)
			OP_BEQ: if (cmpEqual) npcOp = NPC_BRANCH;
			OP_BNE: if (!cmpEqual) npcOp = NPC_BRANCH;
			OP_BGTZ: if (rsPos) npcOp = NPC_BRANCH;
			OP_BLEZ: if (!rsPos) npcOp = NPC_BRANCH; // Zero or negative
			OP_REGIMM: begin
				case (instr.i.rt)
					RT_BGEZ, RT_BGEZAL: if (!rsNeg) npcOp = NPC_BRANCH;
					RT_BLTZ, RT_BLTZAL: if (rsNeg) npcOp = NPC_BRANCH;
					default: npcOp = NPC_SEQ;
				endcase
			end
			OP_J, OP_JAL: npcOp = NPC_JUMP;
			OP_RTYPE: if (isJumpReg) npcOp = NPC_REG;
			default: npcOp = NPC_SEQ;
		endcase
	end

endmodule

/* verilog/writebackDecode.sv */
`timescale 1ns/10ps

module writebackDecode (
	input decodePkg::instrWord instr,
	output logic rfWr,
	output logic [1:0] dstSel,
	output logic [2:0] wbSel,
	output logic aluSrcImm
);
	import decodePkg::*;

	logic isMfc0;

	assign isMfc0 = (instr.r.op == OP_COP0) && (instr.r.rs == RS_MFC0);

	//////////////////////////////////////////////////////////////////////
	// Register-file write enable
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		case (instr.r.op)
			OP_RTYPE: rfWr = instr.r.funct inside {
				FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_NOR, FN_XOR,
				FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_SLT, FN_SLTU,
				FN_JALR, FN_MFHI, FN_MFLO};
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
			OP_ANDI, OP_ORI, OP_XORI, OP_LUI: rfWr = 1'b1;
			OP_REGIMM: rfWr = instr.i.rt inside {RT_BGEZAL, RT_BLTZAL}; // Linking branches
			OP_JAL: rfWr = 1'b1;
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: rfWr = 1'b1;
			OP_COP0: rfWr = isMfc0;
			default: rfWr = 1'b0;
		endcase
	end

	always_comb begin
		case (instr.r.op)
			OP_RTYPE: dstSel = DST_RD;
			OP_REGIMM, OP_JAL: dstSel = DST_RA; // Return address into r31
			default: dstSel = DST_RT;
		endcase
	end

	// Write-back data source
	always_comb begin
		wbSel = WB_ALU;
		case (instr.r.op)
			OP_RTYPE: begin
				if (instr.r.funct inside {FN_MFHI, FN_MFLO, FN_MULT, FN_MULTU, FN_DIV, FN_DIVU})
					wbSel = WB_HILO;
				else if (instr.r.funct == FN_JALR)
					wbSel = WB_LINK;
			end
			OP_REGIMM, OP_JAL: wbSel = WB_LINK;
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: wbSel = WB_MEM;
			OP_LUI: wbSel = WB_IMM;
			OP_COP0: if (isMfc0) wbSel = WB_CP0;
			default: wbSel = WB_ALU;
		endcase
	end

	assign aluSrcImm = (instr.r.op != OP_RTYPE); // Second operand from the extender

endmodule

/* verilog/exceptionDecode.sv */
`timescale 1ns/10ps

module exceptionDecode (
	input logic clk,
	input logic rst,
	input decodePkg::instrWord instr,
	input logic rfWr,
	input logic hiLoWr,
	input logic dmWr,
	input logic bjOp,
	input logic fetchExc,
	input logic fetchFlush,
	input logic [4:0] fetchExcCode,
	output logic excValid,
	output logic [4:0] excCode,
	output logic eretFlush,
	output logic cp0Wr,
	output logic cp0Rd
);
	import decodePkg::*;

	logic resetGuard; // High until the first edge out of reset
	logic isBreak;
	logic isSyscall;
	logic isCop0;
	logic instrValid;

	always_ff @(posedge clk) begin
		if (!rst)
			resetGuard <= 1'b1;
		else
			resetGuard <= 1'b0;
	end

	assign isBreak = (instr.r.op == OP_RTYPE) && (instr.r.funct == FN_BREAK);
	assign isSyscall = (instr.r.op == OP_RTYPE) && (instr.r.funct == FN_SYSCALL);
	assign isCop0 = (instr.r.op == OP_COP0);

	// Anything none of the decoders claims is reserved
	assign instrValid = rfWr || hiLoWr || dmWr || isBreak || isSyscall || isCop0 || bjOp
		|| (instr.r.op == OP_J) || (instr.r.op == OP_JAL);

	//////////////////////////////////////////////////////////////////////
	// Exception priority
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		excValid = 1'b1;
		if (fetchExc)
			excCode = fetchExcCode; // Older exception wins
		else if (!instrValid && !resetGuard && !fetchFlush)
			excCode = EXC_RI;
		else if (isBreak)
			excCode = EXC_BP;
		else if (isSyscall)
			excCode = EXC_SYS;
		else begin
			excValid = 1'b0;
			excCode = EXC_NONE;
		end
	end

	assign eretFlush = isCop0 && (instr.r.funct == FN_ERET);
	assign cp0Wr = isCop0 && (instr.r.rs == RS_MTC0);
	assign cp0Rd = isCop0 && (instr.r.rs == RS_MFC0);

	idleCodeNone: assert property (@(posedge clk) disable iff (!rst)
		!excValid |-> excCode == EXC_NONE);

endmodule

/* verilog/instrDecode.sv */
`timescale 1ns/10ps

module instrDecode (
	input logic clk,
	input logic rst,
	input decodePkg::instrWord instr,
	input logic cmpEqual,
	input logic [1:0] cmpSign,
	input logic fetchExc,
	input logic [4:0] fetchExcCode,
	input logic fetchFlush,
	output logic [3:0] aluOp,
	output logic shamtSel,
	output logic [1:0] extOp,
	output logic hiLoWr,
	output logic mdStart,
	output logic [1:0] mdOp,
	output logic [1:0] hiLoWrSel,
	output logic hiLoRdSel,
	output logic hiLoAccess,
	output logic dmRd,
	output logic dmWr,
	output logic [2:0] dmSel,
	output logic isBranch,
	output logic bjOp,
	output logic [1:0] npcOp,
	output logic rfWr,
	output logic [1:0] dstSel,
	output logic [2:0] wbSel,
	output logic aluSrcImm,
	output logic excValid,
	output logic [4:0] excCode,
	output logic eretFlush,
	output logic cp0Wr,
	output logic cp0Rd
);

	aluDecode uAlu (.instr, .aluOp, .shamtSel, .extOp, .hiLoWr, .mdStart, .mdOp,
		.hiLoWrSel, .hiLoRdSel, .hiLoAccess);

	memDecode uMem (.instr, .dmRd, .dmWr, .dmSel);

	branchDecode uBranch (.instr, .cmpEqual, .cmpSign, .isBranch, .bjOp, .npcOp);

	writebackDecode uWriteback (.instr, .rfWr, .dstSel, .wbSel, .aluSrcImm);

	// rfWr, hiLoWr, dmWr and bjOp double as the valid-instruction terms
	exceptionDecode uException (
		.clk,
		.rst,
		.instr,
		.rfWr,
		.hiLoWr,
		.dmWr,
		.bjOp,
		.fetchExc,
		.fetchFlush,
		.fetchExcCode,
		.excValid,
		.excCode,
		.eretFlush,
		.cp0Wr,
		.cp0Rd
	);

endmodule

/* dv/instrDecodeTb.sv */
`timescale 1ns/10ps

module instrDecodeTb;
	import decodePkg::*;

	logic clk;
	logic rst;
	instrWord instr;
	logic cmpEqual;
	logic [1:0] cmpSign;
	logic fetchExc;
	logic [4:0] fetchExcCode;
	logic fetchFlush;
	logic [3:0] aluOp;
	logic shamtSel;
	logic [1:0] extOp;
	logic hiLoWr;
	logic mdStart;
	logic [1:0] mdOp;
	logic [1:0] hiLoWrSel;
	logic hiLoRdSel;
	logic hiLoAccess;
	logic dmRd;
	logic dmWr;
	logic [2:0] dmSel;
	logic isBranch;
	logic bjOp;
	logic [1:0] npcOp;
	logic rfWr;
	logic [1:0] dstSel;
	logic [2:0] wbSel;
	logic aluSrcImm;
	logic excValid;
	logic [4:0] excCode;
	logic eretFlush;
	logic cp0Wr;
	logic cp0Rd;

	// Model outputs
	logic [3:0] expAluOp;
	logic expShamtSel;
	logic [1:0] expExtOp;
	logic expHiLoWr;
	logic expMdStart;
	logic [1:0] expMdOp;
	logic [1:0] expHiLoWrSel;
	logic expHiLoRdSel;
	logic expHiLoAccess;
	logic expDmRd;
	logic expDmWr;
	logic [2:0] expDmSel;
	logic expIsBranch;
	logic expBjOp;
	logic [1:0] expNpcOp;
	logic expRfWr;
	logic [1:0] expDstSel;
	logic [2:0] expWbSel;
	logic expAluSrcImm;
	logic expExcValid;
	logic [4:0] expExcCode;
	logic expEretFlush;
	logic expCp0Wr;
	logic expCp0Rd;

	int errors;
	int testErrors;
	int testVectors;
	int totalVectors;
	int testCount;
	int waitCount;

	logic [5:0] aluFns [16] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_NOR, FN_XOR,
		FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_SLT, FN_SLTU};
	logic [5:0] immOps [8] = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI,
		OP_LUI};
	logic [5:0] hiLoFns [8] = '{FN_MULT, FN_MULTU, FN_DIV, FN_DIVU, FN_MFHI, FN_MFLO, FN_MTHI,
		FN_MTLO};
	logic [5:0] memOps [8] = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW};
	logic [5:0] unalignedOps [4] = '{6'h22, 6'h26, 6'h2A, 6'h2E}; // LWL LWR SWL SWR
	logic [4:0] regimmRts [4] = '{RT_BLTZ, RT_BGEZ, RT_BLTZAL, RT_BGEZAL};

	instrDecode DUT (.*);

	always #10 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////
	task automatic predict();
		logic [5:0] op;
		logic [5:0] fn;
		logic [4:0] rs;
		logic [4:0] rt;
		logic isR;
		logic isLoad;
		logic isStore;
		logic jumpReg;
		logic taken;
		logic brk;
		logic sys;
		logic valid;
		op = instr.r.op;
		fn = instr.r.funct;
		rs = instr.r.rs;
		rt = instr.i.rt;
		isR = (op == OP_RTYPE);
		isLoad = op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
		isStore = op inside {OP_SB, OP_SH, OP_SW};
		jumpReg = isR && (fn inside {FN_JR, FN_JALR});
		brk = isR && (fn == FN_BREAK);
		sys = isR && (fn == FN_SYSCALL);

		expAluOp = ALU_NONE;
		if (isR) begin
			case (fn)
				FN_ADD: expAluOp = ALU_ADD;
				FN_ADDU: expAluOp = ALU_ADDU;
				FN_SUB: expAluOp = ALU_SUB;
				FN_SUBU: expAluOp = ALU_SUBU;
				FN_AND: expAluOp = ALU_AND;
				FN_OR: expAluOp = ALU_OR;
				FN_NOR: expAluOp = ALU_NOR;
				FN_XOR: expAluOp = ALU_XOR;
				FN_SLL, FN_SLLV: expAluOp = ALU_SLL;
				FN_SRL, FN_SRLV: expAluOp = ALU_SRL;
				FN_SRA, FN_SRAV: expAluOp = ALU_SRA;
				FN_SLT: expAluOp = ALU_SLT;
				FN_SLTU: expAluOp = ALU_SLTU;
				default: expAluOp = ALU_NONE;
			endcase
		end else begin
			case (op)
				OP_ADDI: expAluOp = ALU_ADD;
				OP_ADDIU: expAluOp = ALU_ADDU;
				OP_SLTI: expAluOp = ALU_SLT;
				OP_SLTIU: expAluOp = ALU_SLTU;
				OP_ANDI: expAluOp = ALU_AND;
				OP_ORI: expAluOp = ALU_OR;
				OP_XORI: expAluOp = ALU_XOR;
				default: if (isLoad || isStore) expAluOp = ALU_ADD; // Address add
			endcase
		end
		expShamtSel = isR && (fn inside {FN_SLL, FN_SRL, FN_SRA});
		if ((op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU}) || isLoad || isStore)
			expExtOp = EXT_SIGN;
		else if (op == OP_LUI)
			expExtOp = EXT_UPPER;
		else
			expExtOp = EXT_ZERO;

		// HI/LO group
		expMdStart = isR && (fn inside {FN_MULT, FN_MULTU, FN_DIV, FN_DIVU});
		expHiLoWr = expMdStart || (isR && (fn inside {FN_MTHI, FN_MTLO}));
		case (fn)
			FN_MULT: expMdOp = MD_MULT;
			FN_DIVU: expMdOp = MD_DIVU;
			FN_DIV: expMdOp = MD_DIV;
			default: expMdOp = MD_MULTU;
		endcase
		if (expMdStart)
			expHiLoWrSel = 2'd2;
		else if (isR && (fn == FN_MTHI))
			expHiLoWrSel = 2'd1;
		else
			expHiLoWrSel = 2'd0;
		expHiLoRdSel = isR && (fn == FN_MFHI);
		expHiLoAccess = expHiLoWr || (isR && (fn inside {FN_MFHI, FN_MFLO}));

		// Data memory
		expDmRd = isLoad;
		expDmWr = isStore;
		case (op)
			OP_SB: expDmSel = DM_SB;
			OP_SH: expDmSel = DM_SH;
			OP_SW: expDmSel = DM_SW;
			OP_LBU: expDmSel = DM_LBU;
			OP_LB: expDmSel = DM_LB;
			OP_LHU: expDmSel = DM_LHU;
			OP_LH: expDmSel = DM_LH;
			default: expDmSel = DM_WORD;
		endcase

		// Branch condition table
		expBjOp = jumpReg || (op inside {OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ})
			|| ((op == OP_REGIMM) && (rt inside {RT_BLTZ, RT_BGEZ, RT_BLTZAL, RT_BGEZAL}));
		expIsBranch = expBjOp || (op == OP_J) || (op == OP_JAL);
		taken = 1'b0;
		if (op == OP_BEQ)
			taken = cmpEqual;
		else if (op == OP_BNE)
			taken = !cmpEqual;
		else if (op == OP_BLEZ)
			taken = (cmpSign != 2'b01);
		else if (op == OP_BGTZ)
			taken = (cmpSign == 2'b01);
		else if ((op == OP_REGIMM) && (rt inside {RT_BGEZ, RT_BGEZAL}))
			taken = (cmpSign != 2'b10);
		else if ((op == OP_REGIMM) && (rt inside {RT_BLTZ, RT_BLTZAL}))
			taken = (cmpSign == 2'b10);
		if (taken)
			expNpcOp = NPC_BRANCH;
		else if ((op == OP_J) || (op == OP_JAL))
			expNpcOp = NPC_JUMP;
		else if (jumpReg)
			expNpcOp = NPC_REG;
		else
			expNpcOp = NPC_SEQ;

		// Write-back
		expRfWr = (isR && ((expAluOp != ALU_NONE) || (fn inside {FN_JALR, FN_MFHI, FN_MFLO})))
			|| (op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI})
			|| isLoad || (op == OP_JAL)
			|| ((op == OP_REGIMM) && (rt inside {RT_BGEZAL, RT_BLTZAL}))
			|| ((op == OP_COP0) && (rs == RS_MFC0));
		if (isR)
			expDstSel = DST_RD;
		else if ((op == OP_REGIMM) || (op == OP_JAL))
			expDstSel = DST_RA;
		else
			expDstSel = DST_RT;
		if (isR && (expMdStart || (fn inside {FN_MFHI, FN_MFLO})))
			expWbSel = WB_HILO;
		else if ((isR && (fn == FN_JALR)) || (op == OP_REGIMM) || (op == OP_JAL))
			expWbSel = WB_LINK;
		else if (isLoad)
			expWbSel = WB_MEM;
		else if (op == OP_LUI)
			expWbSel = WB_IMM;
		else if ((op == OP_COP0) && (rs == RS_MFC0))
			expWbSel = WB_CP0;
		else
			expWbSel = WB_ALU;
		expAluSrcImm = !isR;

		// Exceptions, reset guard already released
		valid = expRfWr || expHiLoWr || expDmWr || brk || sys || (op == OP_COP0) || expBjOp
			|| (op == OP_J) || (op == OP_JAL);
		expExcValid = 1'b1;
		if (fetchExc)
			expExcCode = fetchExcCode;
		else if (!valid && !fetchFlush)
			expExcCode = EXC_RI;
		else if (brk)
			expExcCode = EXC_BP;
		else if (sys)
			expExcCode = EXC_SYS;
		else begin
			expExcValid = 1'b0;
			expExcCode = EXC_NONE;
		end
		expEretFlush = (op == OP_COP0) && (fn == FN_ERET);
		expCp0Wr = (op == OP_COP0) && (rs == RS_MTC0);
		expCp0Rd = (op == OP_COP0) && (rs == RS_MFC0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Checking
	//////////////////////////////////////////////////////////////////////
	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("error: %s got %h, expected %h (instr %h)", name, got, exp, instr);
			errors++;
			testErrors++;
		end
	endtask

	task automatic checkOutputs();
		compare("aluOp", 32'(aluOp), 32'(expAluOp));
		compare("shamtSel", 32'(shamtSel), 32'(expShamtSel));
		compare("extOp", 32'(extOp), 32'(expExtOp));
		compare("hiLoWr", 32'(hiLoWr), 32'(expHiLoWr));
		compare("mdStart", 32'(mdStart), 32'(expMdStart));
		if (expMdStart)
			compare("mdOp", 32'(mdOp), 32'(expMdOp)); // Only meaningful with mdStart
		compare("hiLoWrSel", 32'(hiLoWrSel), 32'(expHiLoWrSel));
		compare("hiLoRdSel", 32'(hiLoRdSel), 32'(expHiLoRdSel));
		compare("hiLoAccess", 32'(hiLoAccess), 32'(expHiLoAccess));
		compare("dmRd", 32'(dmRd), 32'(expDmRd));
		compare("dmWr", 32'(dmWr), 32'(expDmWr));
		compare("dmSel", 32'(dmSel), 32'(expDmSel));
		compare("isBranch", 32'(isBranch), 32'(expIsBranch));
		compare("bjOp", 32'(bjOp), 32'(expBjOp));
		compare("npcOp", 32'(npcOp), 32'(expNpcOp));
		compare("rfWr", 32'(rfWr), 32'(expRfWr));
		compare("dstSel", 32'(dstSel), 32'(expDstSel));
		compare("wbSel", 32'(wbSel), 32'(expWbSel));
		compare("aluSrcImm", 32'(aluSrcImm), 32'(expAluSrcImm));
		compare("excValid", 32'(excValid), 32'(expExcValid));
		compare("excCode", 32'(excCode), 32'(expExcCode));
		compare("eretFlush", 32'(eretFlush), 32'(expEretFlush));
		compare("cp0Wr", 32'(cp0Wr), 32'(expCp0Wr));
		compare("cp0Rd", 32'(cp0Rd), 32'(expCp0Rd));
	endtask

	// Drive 2 ns after the edge, check 2 ns before the next one
	task automatic applyVector(input logic [31:0] word, input logic eq, input logic [1:0] sign,
		input logic fexc, input logic [4:0] fcode, input logic fflush);
		@(posedge clk);
		#2;
		instr = word;
		cmpEqual = eq;
		cmpSign = sign;
		fetchExc = fexc;
		fetchExcCode = fcode;
		fetchFlush = fflush;
		#16;
		predict();
		checkOutputs();
		testVectors++;
		totalVectors++;
	endtask

	function automatic logic [31:0] makeWord(input logic [5:0] op, input logic [5:0] fn);
		return {op, 5'($urandom), 5'($urandom), 5'($urandom), 5'($urandom), fn};
	endfunction

	function automatic logic rare();
		return ($urandom % 32) == 0;
	endfunction

	function automatic logic [5:0] reservedOp();
		logic [31:0] pick;
		pick = $urandom % 3;
		if (pick == 0)
			return unalignedOps[2'($urandom)];
		else if (pick == 1)
			return 6'h11 + 6'($urandom % 15);
		else
			return 6'h30 + 6'($urandom % 16);
	endfunction

	task automatic startTest();
		testErrors = 0;
		testVectors = 0;
		testCount++;
	endtask

	task automatic reportTest(input string name);
		$display("%s: %0d vectors, %0d errors", name, testVectors, testErrors);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////
	task automatic testAlu();
		logic [31:0] word;
		startTest();
		for (int n = 0; n < 300; n++) begin
			if (($urandom % 8) == 0)
				word = $urandom; // Fully random word
			else if (($urandom % 2) == 0)
				word = makeWord(OP_RTYPE, aluFns[4'($urandom)]);
			else
				word = makeWord(immOps[3'($urandom)], 6'($urandom));
			applyVector(word, 1'($urandom), 2'($urandom % 3), rare(), 5'($urandom), rare());
		end
		reportTest("ALU decode");
	endtask

	task automatic testHiLo();
		startTest();
		for (int n = 0; n < 80; n++)
			applyVector(makeWord(OP_RTYPE, hiLoFns[3'($urandom)]), 1'($urandom),
				2'($urandom % 3), rare(), 5'($urandom), rare());
		reportTest("HI/LO decode");
	endtask

	task automatic testMem();
		startTest();
		for (int n = 0; n < 120; n++)
			applyVector(makeWord(memOps[3'($urandom)], 6'($urandom)), 1'($urandom),
				2'($urandom % 3), rare(), 5'($urandom), rare());
		reportTest("memory decode");
	endtask

	task automatic testBranch();
		logic [31:0] word;
		startTest();
		for (int n = 0; n < 200; n++) begin
			case ($urandom % 9)
				0: word = makeWord(OP_BEQ, 6'($urandom));
				1: word = makeWord(OP_BNE, 6'($urandom));
				2: word = makeWord(OP_BLEZ, 6'($urandom));
				3: word = makeWord(OP_BGTZ, 6'($urandom));
				4: begin
					word = makeWord(OP_REGIMM, 6'($urandom));
					word[20:16] = regimmRts[2'($urandom)];
				end
				5: word = makeWord(OP_J, 6'($urandom));
				6: word = makeWord(OP_JAL, 6'($urandom));
				7: word = makeWord(OP_RTYPE, FN_JR);
				default: word = makeWord(OP_RTYPE, FN_JALR);
			endcase
			applyVector(word, 1'($urandom), 2'($urandom % 3), rare(), 5'($urandom), rare());
		end
		reportTest("branch decode");
	endtask

	task automatic testExceptions();
		logic [31:0] word;
		startTest();
		for (int n = 0; n < 200; n++) begin
			case ($urandom % 4)
				1: word = makeWord(OP_RTYPE, FN_BREAK);
				2: word = makeWord(OP_RTYPE, FN_SYSCALL);
				default: word = makeWord(reservedOp(), 6'($urandom)); // Invalid word
			endcase
			applyVector(word, 1'($urandom), 2'($urandom % 3), ($urandom % 4) == 0,
				5'($urandom), ($urandom % 4) == 0);
		end
		reportTest("exceptions");
	endtask

	task automatic testCp0();
		logic [31:0] word;
		startTest();
		for (int n = 0; n < 60; n++) begin
			case ($urandom % 3)
				0: word = {OP_COP0, 5'b10000, 15'd0, FN_ERET};
				1: word = {OP_COP0, RS_MTC0, 5'($urandom), 5'($urandom), 11'd0};
				default: word = {OP_COP0, RS_MFC0, 5'($urandom), 5'($urandom), 11'd0};
			endcase
			applyVector(word, 1'($urandom), 2'($urandom % 3), 1'b0, 5'd0, 1'b0);
		end
		reportTest("coprocessor 0");
	endtask

	initial begin
		void'($urandom(87491));
		errors = 0;
		totalVectors = 0;
		testCount = 0;
		clk = 1'b0;
		rst = 1'b0;
		instr = 32'hFC00_0000; // Reserved opcode, RI held off by the guard
		cmpEqual = 1'b0;
		cmpSign = 2'b00;
		fetchExc = 1'b0;
		fetchExcCode = 5'd0;
		fetchFlush = 1'b0;

		repeat (8) @(posedge clk);
		#2;
		if (excValid !== 1'b0) begin
			$display("reserved instruction raised an exception while in reset");
			errors++;
		end
		rst = 1'b1;

		// Guard clears on the first edge with rst high
		waitCount = 0;
		while ((excValid !== 1'b1) && (waitCount < 10)) begin
			@(posedge clk);
			#2;
			waitCount++;
		end
		if (excValid !== 1'b1) begin
			$display("timeout waiting for the reset guard to clear");
			$display("*** TEST FAILED ***");
		end else begin
			testAlu();
			testHiLo();
			testMem();
			testBranch();
			testExceptions();
			testCp0();

			$display("%0d tests, %0d vectors, %0d errors", testCount, totalVectors, errors);
			if (errors == 0) begin
				$display("*** TEST PASSED ***");
			end else begin
				$display("*** TEST FAILED ***");
			end
		end
		$finish;
	end

endmodule

/* instrDecode.f */
verilog/decodePkg.sv
verilog/aluDecode.sv
verilog/memDecode.sv
verilog/branchDecode.sv
verilog/writebackDecode.sv
verilog/exceptionDecode.sv
verilog/instrDecode.sv
dv/instrDecodeTb.sv

/* Makefile */
VERILATOR ?= verilator
TB_TOP ?= instrDecodeTb
FILELIST ?= instrDecode.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_TEXT ?= *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

clean:
	rm -rf $(OBJ_DIR)
